/* flist.f */
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_top.sv
verif/cpu_props.sv
verif/cpu_tb.sv

/* Makefile */
TOP   ?= cpu_tb
FLIST ?= flist.f
LOG   ?= sim.log
VERILATOR ?= verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "variables: TOP FLIST LOG VERILATOR"

test:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*;;

  localparam int num_rows  = 9;
  localparam int row_words = 12;
  localparam int load_words = 16;          // program plus zero padding
  localparam int max_wait  = 300;

  logic       clk;
  logic       reset;
  logic       imem_we;
  logic [9:0] imem_addr;
  logic [31:0] imem_wdata;
  logic [3:0] key;
  logic [9:0] ledr;
  logic [6:0] hex0;
  logic [6:0] hex1;
  logic [6:0] hex2;
  logic [6:0] hex3;
  logic [6:0] hex4;
  logic [6:0] hex5;
  logic [6:0] hex_out [0:5];

  // stimulus table
  logic [31:0] prog [0:num_rows-1][0:row_words-1];
  logic [3:0]  row_key [0:num_rows-1];
  logic [9:0]  row_ledr [0:num_rows-1];
  logic [23:0] row_hex [0:num_rows-1];
  int          cur_row;
  int          cur_len;

  int errors;
  int timeouts;
  int checks;

  cpu_top #(.imem_addr_bits(10), .dmem_addr_bits(10)) uut (.*);

  assign hex_out[0] = hex0;
  assign hex_out[1] = hex1;
  assign hex_out[2] = hex2;
  assign hex_out[3] = hex3;
  assign hex_out[4] = hex4;
  assign hex_out[5] = hex5;

  always #5 clk = ~clk;

  // ----------------------------------------
  // instruction encoders
  // ----------------------------------------
  function automatic logic [31:0] alur(input logic [7:0] op2, input logic [3:0] rd,
                                       input logic [3:0] rs, input logic [3:0] rt);
    return {op1_alur, op2, 6'b0, rd, rs, rt};
  endfunction

  function automatic logic [31:0] immi(input logic [5:0] op1, input logic [3:0] rt,
                                       input logic [3:0] rs, input logic [15:0] imm);
    return {op1, 2'b0, imm, rs, rt};
  endfunction

  // compares rs against rt, offset in words
  function automatic logic [31:0] branch(input logic [5:0] op1, input logic [3:0] rs,
                                         input logic [3:0] rt, input logic [15:0] imm);
    return immi(op1, rt, rs, imm);
  endfunction

  function automatic logic [31:0] store(input logic [3:0] rt, input logic [3:0] rs,
                                        input logic [15:0] imm);
    return immi(op1_sw, rt, rs, imm);
  endfunction

  // active-low digit patterns, g is bit 6
  function automatic logic [6:0] digit_pattern(input logic [3:0] d);
    logic [6:0] table_val [0:15];
    table_val = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    return table_val[d];
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[cur_row][cur_len] = word;
    cur_len++;
  endtask

  // closes a row with the self loop, BEQ r0, r0, -1
  task automatic end_row(input logic [3:0] k, input logic [9:0] exp_ledr,
                         input logic [23:0] exp_hex);
    emit(branch(op1_beq, 4'd0, 4'd0, 16'hFFFF));
    row_key[cur_row]  = k;
    row_ledr[cur_row] = exp_ledr;
    row_hex[cur_row]  = exp_hex;
    cur_row++;
    cur_len = 0;
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, actual, expected);
    end
  endtask

  task automatic check_outputs(input logic [9:0] exp_ledr, input logic [23:0] exp_hex);
    string name;
    compare("ledr", 32'(ledr), 32'(exp_ledr));
    for (int d = 0; d < 6; d++) begin
      name = $sformatf("hex%0d", d);
      compare(name, 32'(hex_out[d]), 32'(digit_pattern(exp_hex[4*d +: 4])));
    end
  endtask

  // ----------------------------------------
  // program table
  // ----------------------------------------
  task automatic build_table();
    cur_row = 0;
    cur_len = 0;
    for (int r = 0; r < num_rows; r++) begin
      for (int w = 0; w < row_words; w++) begin
        prog[r][w] = '0;
      end
    end
    // dependent alur chain: add, sub, xor, lshf, or
    emit(immi(op1_addi, 4'd1, 4'd0, 16'd5));
    emit(immi(op1_addi, 4'd2, 4'd0, 16'd3));
    emit(alur(op2_add, 4'd3, 4'd1, 4'd2));    // 8
    emit(alur(op2_sub, 4'd4, 4'd3, 4'd1));    // 3
    emit(alur(op2_xor, 4'd5, 4'd4, 4'd3));    // 0xb
    emit(alur(op2_lshf, 4'd6, 4'd5, 4'd2));   // 0x58
    emit(alur(op2_or, 4'd7, 4'd6, 4'd4));     // 0x5b
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(store(4'd7, 4'd14, 16'h0000));
    emit(store(4'd7, 4'd14, 16'h0020));
    end_row(4'hF, 10'h05B, 24'h00005B);
    // rshf, nand, nor, nxor, and
    emit(immi(op1_addi, 4'd1, 4'd0, 16'hFFF0));
    emit(immi(op1_addi, 4'd2, 4'd0, 16'd2));
    emit(alur(op2_rshf, 4'd3, 4'd1, 4'd2));   // fffffffc
    emit(alur(op2_nand, 4'd4, 4'd3, 4'd1));   // 0000000f
    emit(alur(op2_nor, 4'd5, 4'd4, 4'd2));    // fffffff0
    emit(alur(op2_nxor, 4'd6, 4'd5, 4'd3));   // fffffff3
    emit(alur(op2_and, 4'd7, 4'd6, 4'd5));    // fffffff0
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(store(4'd7, 4'd14, 16'h0000));
    emit(store(4'd7, 4'd14, 16'h0020));
    end_row(4'hF, 10'h3F0, 24'hFFFFF0);
    // signed compares
    emit(immi(op1_addi, 4'd1, 4'd0, 16'hFFFF));
    emit(immi(op1_addi, 4'd2, 4'd0, 16'd1));
    emit(alur(op2_lt, 4'd3, 4'd1, 4'd2));     // -1 < 1
    emit(alur(op2_le, 4'd4, 4'd2, 4'd1));     // 1 <= -1 is false
    emit(alur(op2_ne, 4'd5, 4'd4, 4'd3));
    emit(alur(op2_eq, 4'd6, 4'd4, 4'd0));
    emit(alur(op2_lshf, 4'd7, 4'd6, 4'd5));   // 2
    emit(alur(op2_add, 4'd8, 4'd7, 4'd3));    // 3
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(store(4'd8, 4'd14, 16'h0000));
    emit(store(4'd8, 4'd14, 16'h0020));
    end_row(4'hF, 10'h003, 24'h000003);
    // immediates with negative values
    emit(immi(op1_addi, 4'd1, 4'd0, 16'hFFFE));
    emit(immi(op1_andi, 4'd2, 4'd1, 16'hFF0F)); // ffffff0e
    emit(immi(op1_xori, 4'd3, 4'd2, 16'hF0F0)); // 00000ffe
    emit(immi(op1_ori, 4'd4, 4'd3, 16'h8001));  // ffff8fff
    emit(immi(op1_andi, 4'd5, 4'd4, 16'hFFF0)); // ffff8ff0
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(store(4'd5, 4'd14, 16'h0000));
    emit(store(4'd5, 4'd14, 16'h0020));
    end_row(4'hF, 10'h3F0, 24'hFF8FF0);
    // store, load, dependent add right behind the load
    emit(immi(op1_addi, 4'd1, 4'd0, 16'h0040));
    emit(immi(op1_addi, 4'd2, 4'd0, 16'h0123));
    emit(store(4'd2, 4'd1, 16'h0004));
    emit(immi(op1_lw, 4'd3, 4'd1, 16'h0004));
    emit(alur(op2_add, 4'd4, 4'd3, 4'd2));
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(store(4'd4, 4'd14, 16'h0000));
    emit(store(4'd4, 4'd14, 16'h0020));
    end_row(4'hF, 10'h246, 24'h000246);
    // blt and beq taken, bne and ble not taken
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(immi(op1_addi, 4'd1, 4'd0, 16'hFFFF));
    emit(immi(op1_addi, 4'd2, 4'd0, 16'd2));
    emit(branch(op1_blt, 4'd1, 4'd2, 16'd1));
    emit(store(4'd1, 4'd14, 16'h0020));        // flushed
    emit(branch(op1_bne, 4'd1, 4'd1, 16'd2));
    emit(branch(op1_ble, 4'd2, 4'd1, 16'd1));
    emit(branch(op1_beq, 4'd1, 4'd1, 16'd1));
    emit(store(4'd1, 4'd14, 16'h0020));        // flushed
    emit(store(4'd2, 4'd14, 16'h0000));
    emit(store(4'd2, 4'd14, 16'h0020));
    end_row(4'hF, 10'h002, 24'h000002);
    // beq and blt not taken, bne and ble taken
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(immi(op1_addi, 4'd1, 4'd0, 16'd1));
    emit(immi(op1_addi, 4'd2, 4'd0, 16'd6));
    emit(branch(op1_beq, 4'd1, 4'd2, 16'd2));
    emit(branch(op1_blt, 4'd2, 4'd1, 16'd1));
    emit(branch(op1_bne, 4'd1, 4'd2, 16'd1));
    emit(store(4'd1, 4'd14, 16'h0020));
    emit(branch(op1_ble, 4'd1, 4'd1, 16'd1));
    emit(store(4'd1, 4'd14, 16'h0020));
    emit(store(4'd2, 4'd14, 16'h0000));
    emit(store(4'd2, 4'd14, 16'h0020));
    end_row(4'hF, 10'h006, 24'h000006);
    // jal at 0x108 to 0x114, link is 0x10c
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(immi(op1_addi, 4'd1, 4'd0, 16'd7));
    emit(immi(op1_jal, 4'd5, 4'd0, 16'h0045));
    emit(store(4'd1, 4'd14, 16'h0020));
    emit(store(4'd1, 4'd14, 16'h0020));
    emit(store(4'd5, 4'd14, 16'h0000));
    emit(store(4'd5, 4'd14, 16'h0020));
    end_row(4'hF, 10'h10C, 24'h00010C);
    // key read, keys are active low
    emit(immi(op1_addi, 4'd14, 4'd0, 16'hF000));
    emit(immi(op1_lw, 4'd1, 4'd14, 16'h0080));
    emit(store(4'd1, 4'd14, 16'h0000));
    emit(store(4'd1, 4'd14, 16'h0020));
    end_row(4'b0101, 10'h00A, 24'h00000A);
  endtask

  // ----------------------------------------
  // one row: reset, load, run, check
  // ----------------------------------------
  task automatic run_row(input int r);
    int  cycles;
    bit  wrong_seen;
    for (int i = 0; i < load_words; i++) begin
      @(posedge clk);
      reset      <= 1'b1;
      key        <= row_key[r];
      imem_we    <= 1'b1;
      imem_addr  <= 10'(64 + i);              // start_pc is word 64
      imem_wdata <= (i < row_words) ? prog[r][i] : 32'h0;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    reset   <= 1'b0;
    @(negedge clk);
    check_outputs(10'h000, 24'h000000);       // nothing stored yet
    cycles     = 0;
    wrong_seen = 0;
    while (ledr !== row_ledr[r] && cycles < max_wait) begin
      if (ledr !== 10'h000 && !wrong_seen) begin
        wrong_seen = 1;
        compare("ledr", 32'(ledr), 32'(row_ledr[r])); // stray store reached ledr
      end
      @(negedge clk);
      cycles++;
    end
    if (ledr !== row_ledr[r]) begin
      timeouts++;
      $display("row %0d: ledr never reached %h within %0d cycles", r, row_ledr[r],
               max_wait);
    end else begin
      check_outputs(row_ledr[r], row_hex[r]);
    end
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    key        = 4'hF;
    errors     = 0;
    timeouts   = 0;
    checks     = 0;
    build_table();
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/cpu_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic redirect,
  input logic dec_wr_reg,
  input logic ex_q_wr_reg,
  input logic wb_wr_reg,
  input logic ex_q_wr_mem
);

  // ----------------------------------------
  // pipeline control
  // ----------------------------------------
  no_stall_on_redirect: assert property (@(posedge clk) disable iff (reset)
    !(stall && redirect))
    else $error("stall and redirect high together");

  quiet_in_reset: assert property (@(posedge clk)
    reset |-> !dec_wr_reg && !ex_q_wr_reg && !wb_wr_reg && !ex_q_wr_mem)
    else $error("write enable active during reset");

  single_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> !stall)     // load-use bubble is one cycle
    else $error("stall longer than one cycle");

endmodule

bind cpu_top cpu_props u_props (.*);

`default_nettype wire

/* hdl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter int imem_addr_bits = 10,
  parameter int dmem_addr_bits = 10
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      imem_we,
  input  logic [imem_addr_bits-1:0] imem_addr,
  input  logic [31:0]               imem_wdata,
  input  logic [3:0]                key,
  output logic [9:0]                ledr,
  output logic [6:0]                hex0,
  output logic [6:0]                hex1,
  output logic [6:0]                hex2,
  output logic [6:0]                hex3,
  output logic [6:0]                hex4,
  output logic [6:0]                hex5
);

  // fetch to decode
  logic [dbits-1:0]      fetch_pc;
  inst_t                 fetch_inst;
  logic                  stall;

  // decode to execute
  logic [dbits-1:0]      dec_pc;
  inst_t                 dec_inst;
  logic [dbits-1:0]      dec_rs_val;
  logic [dbits-1:0]      dec_rt_val;
  logic [dbits-1:0]      dec_imm;
  logic [regno_bits-1:0] dec_wregno;
  logic                  dec_wr_reg;
  logic                  dec_valid;

  // execute outputs, redirect and forwarding
  logic                  redirect;
  logic [dbits-1:0]      redirect_pc;
  logic [dbits-1:0]      ex_result;
  logic [regno_bits-1:0] ex_wregno;
  logic                  ex_wr_reg;
  logic                  ex_is_load;
  logic [dbits-1:0]      ex_q_result;
  logic [dbits-1:0]      ex_q_store_data;
  logic [regno_bits-1:0] ex_q_wregno;
  logic                  ex_q_wr_reg;
  logic                  ex_q_rd_mem;
  logic                  ex_q_wr_mem;

  // memory stage back to decode
  logic [dbits-1:0]      mem_fwd_value;
  logic                  wb_wr_reg;
  logic [regno_bits-1:0] wb_wregno;
  logic [dbits-1:0]      wb_value;

  // ----------------------------------------
  // pipeline stages, ports match by name
  // ----------------------------------------
  fetch_stage #(.imem_addr_bits(imem_addr_bits)) u_fetch (.*);

  decode_stage u_decode (.*);

  execute_stage u_execute (.*);

  memory_stage #(.dmem_addr_bits(dmem_addr_bits)) u_memory (.*);

endmodule

`default_nettype wire

/* hdl/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; #(
  parameter int dmem_addr_bits = 10
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [dbits-1:0]      ex_q_result,
  input  logic [dbits-1:0]      ex_q_store_data,
  input  logic [regno_bits-1:0] ex_q_wregno,
  input  logic                  ex_q_wr_reg,
  input  logic                  ex_q_rd_mem,
  input  logic                  ex_q_wr_mem,
  input  logic [3:0]            key,
  output logic [dbits-1:0]      mem_fwd_value,
  output logic                  wb_wr_reg,
  output logic [regno_bits-1:0] wb_wregno,
  output logic [dbits-1:0]      wb_value,
  output logic [9:0]            ledr,
  output logic [6:0]            hex0,
  output logic [6:0]            hex1,
  output logic [6:0]            hex2,
  output logic [6:0]            hex3,
  output logic [6:0]            hex4,
  output logic [6:0]            hex5
);

  logic [dbits-1:0]          dmem [0:(1<<dmem_addr_bits)-1];
  logic [dmem_addr_bits-1:0] dmem_idx;
  logic                      sel_key;
  logic                      sel_ledr;
  logic                      sel_hex;
  logic [dbits-1:0]          load_val;
  logic [23:0]               hex_q;

  // active-low segments, bit 6 is g
  function automatic logic [6:0] seg7(input logic [3:0] d);
    case (d)
      4'h0: seg7 = 7'b1000000;
      4'h1: seg7 = 7'b1111001;
      4'h2: seg7 = 7'b0100100;
      4'h3: seg7 = 7'b0110000;
      4'h4: seg7 = 7'b0011001;
      4'h5: seg7 = 7'b0010010;
      4'h6: seg7 = 7'b0000010;
      4'h7: seg7 = 7'b1111000;
      4'h8: seg7 = 7'b0000000;
      4'h9: seg7 = 7'b0010000;
      4'hA: seg7 = 7'b0001000;
      4'hB: seg7 = 7'b0000011;
      4'hC: seg7 = 7'b1000110;
      4'hD: seg7 = 7'b0100001;
      4'hE: seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;
    endcase
  endfunction

  // ----------------------------------------
  // address decode and data memory
  // ----------------------------------------
  assign sel_key  = (ex_q_result == addr_key);
  assign sel_ledr = (ex_q_result == addr_ledr);
  assign sel_hex  = (ex_q_result == addr_hex);
  assign dmem_idx = ex_q_result[dmem_addr_bits+1:2];

  always_ff @(posedge clk) begin
    if (ex_q_wr_mem && !sel_key && !sel_ledr && !sel_hex) begin
      dmem[dmem_idx] <= ex_q_store_data;
    end
  end

  // keys are active low on the board
  assign load_val      = sel_key ? {{(dbits-4){1'b0}}, ~key} : dmem[dmem_idx];
  assign mem_fwd_value = ex_q_rd_mem ? load_val : ex_q_result;

  // output devices
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr  <= '0;
      hex_q <= '0;
    end else if (ex_q_wr_mem) begin
      if (sel_ledr) begin
        ledr <= ex_q_store_data[9:0];
      end
      if (sel_hex) begin
        hex_q <= ex_q_store_data[23:0];
      end
    end
  end

  assign hex0 = seg7(hex_q[3:0]);
  assign hex1 = seg7(hex_q[7:4]);
  assign hex2 = seg7(hex_q[11:8]);
  assign hex3 = seg7(hex_q[15:12]);
  assign hex4 = seg7(hex_q[19:16]);
  assign hex5 = seg7(hex_q[23:20]);

  // writeback latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_wr_reg <= 1'b0;
    end else begin
      wb_wr_reg <= ex_q_wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    wb_wregno <= ex_q_wregno;
    wb_value  <= mem_fwd_value;
  end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [dbits-1:0]      dec_pc,
  input  inst_t                 dec_inst,
  input  logic [dbits-1:0]      dec_rs_val,
  input  logic [dbits-1:0]      dec_rt_val,
  input  logic [dbits-1:0]      dec_imm,
  input  logic [regno_bits-1:0] dec_wregno,
  input  logic                  dec_wr_reg,
  input  logic                  dec_valid,
  output logic                  redirect,
  output logic [dbits-1:0]      redirect_pc,
  output logic [dbits-1:0]      ex_result,
  output logic [regno_bits-1:0] ex_wregno,
  output logic                  ex_wr_reg,
  output logic                  ex_is_load,
  output logic [dbits-1:0]      ex_q_result,
  output logic [dbits-1:0]      ex_q_store_data,
  output logic [regno_bits-1:0] ex_q_wregno,
  output logic                  ex_q_wr_reg,
  output logic                  ex_q_rd_mem,
  output logic                  ex_q_wr_mem
);

  logic [5:0]              op1;
  logic [7:0]              op2;
  logic signed [dbits-1:0] a;
  logic signed [dbits-1:0] b;
  logic [dbits-1:0]        alur_val;
  logic                    br_cond;
  logic                    is_jal;
  logic                    taken;
  logic [dbits-1:0]        target;

  assign op1 = dec_inst.alu_fmt.op1;
  assign op2 = dec_inst.alu_fmt.op2;
  assign a   = dec_rs_val;
  assign b   = dec_rt_val;

  // ----------------------------------------
  // alu
  // ----------------------------------------
  always_comb begin
    case (op2)
      op2_eq:   alur_val = {{(dbits-1){1'b0}}, a == b};
      op2_lt:   alur_val = {{(dbits-1){1'b0}}, a < b};   // signed compares
      op2_le:   alur_val = {{(dbits-1){1'b0}}, a <= b};
      op2_ne:   alur_val = {{(dbits-1){1'b0}}, a != b};
      op2_add:  alur_val = a + b;
      op2_and:  alur_val = a & b;
      op2_or:   alur_val = a | b;
      op2_xor:  alur_val = a ^ b;
      op2_sub:  alur_val = a - b;
      op2_nand: alur_val = ~(a & b);
      op2_nor:  alur_val = ~(a | b);
      op2_nxor: alur_val = ~(a ^ b);
      op2_rshf: alur_val = a >>> b[4:0];                  // arithmetic
      op2_lshf: alur_val = a << b[4:0];
      default:  alur_val = '0;
    endcase
  end

  always_comb begin
    case (op1)
      op1_alur: ex_result = alur_val;
      op1_lw,
      op1_sw,
      op1_addi: ex_result = a + dec_imm;                  // also the mem address
      op1_andi: ex_result = a & dec_imm;
      op1_ori:  ex_result = a | dec_imm;
      op1_xori: ex_result = a ^ dec_imm;
      op1_jal:  ex_result = dec_pc + 32'd4;               // return address
      default:  ex_result = '0;
    endcase
  end

  // branch condition and target
  always_comb begin
    case (op1)
      op1_beq: br_cond = (a == b);
      op1_blt: br_cond = (a < b);
      op1_ble: br_cond = (a <= b);
      op1_bne: br_cond = (a != b);
      default: br_cond = 1'b0;
    endcase
  end

  assign is_jal = (op1 == op1_jal);
  assign taken  = dec_valid && (is_jal || br_cond);
  assign target = is_jal ? a + (dec_imm << 2) : dec_pc + 32'd4 + (dec_imm << 2);

  assign ex_wregno  = dec_wregno;
  assign ex_wr_reg  = dec_wr_reg;
  assign ex_is_load = dec_valid && !redirect && (op1 == op1_lw); // flushed load stalls nothing

  // ----------------------------------------
  // execute latch
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect    <= 1'b0;
      ex_q_wr_reg <= 1'b0;
      ex_q_rd_mem <= 1'b0;
      ex_q_wr_mem <= 1'b0;
    end else if (redirect) begin
      // slot right behind the taken branch is dropped here
      redirect    <= 1'b0;
      ex_q_wr_reg <= 1'b0;
      ex_q_rd_mem <= 1'b0;
      ex_q_wr_mem <= 1'b0;
    end else begin
      redirect    <= taken;
      ex_q_wr_reg <= dec_wr_reg;
      ex_q_rd_mem <= ex_is_load;
      ex_q_wr_mem <= dec_valid && (op1 == op1_sw);
    end
  end

  always_ff @(posedge clk) begin
    redirect_pc     <= target;
    ex_q_result     <= ex_result;
    ex_q_store_data <= dec_rt_val;
    ex_q_wregno     <= dec_wregno;
  end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [dbits-1:0]      fetch_pc,
  input  inst_t                 fetch_inst,
  input  logic                  redirect,
  input  logic [dbits-1:0]      ex_result,
  input  logic [regno_bits-1:0] ex_wregno,
  input  logic                  ex_wr_reg,
  input  logic                  ex_is_load,
  input  logic [dbits-1:0]      mem_fwd_value,
  input  logic [regno_bits-1:0] ex_q_wregno,
  input  logic                  ex_q_wr_reg,
  input  logic                  wb_wr_reg,
  input  logic [regno_bits-1:0] wb_wregno,
  input  logic [dbits-1:0]      wb_value,
  output logic                  stall,
  output logic [dbits-1:0]      dec_pc,
  output inst_t                 dec_inst,
  output logic [dbits-1:0]      dec_rs_val,
  output logic [dbits-1:0]      dec_rt_val,
  output logic [dbits-1:0]      dec_imm,
  output logic [regno_bits-1:0] dec_wregno,
  output logic                  dec_wr_reg,
  output logic                  dec_valid
);

  logic [5:0]            op1;
  logic [regno_bits-1:0] rd;
  logic [regno_bits-1:0] rs;
  logic [regno_bits-1:0] rt;
  logic [15:0]           imm;
  logic                  is_alur;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_load;
  logic                  is_store;
  logic                  is_alui;
  logic                  uses_rt;
  logic [regno_bits-1:0] wregno;
  logic                  wr_reg;
  logic [dbits-1:0]      rs_val;
  logic [dbits-1:0]      rt_val;
  logic [dbits-1:0]      regs [0:(1<<regno_bits)-1];

  // register numbers from the alu view, immediate from the imm view
  assign op1 = fetch_inst.alu_fmt.op1;
  assign rd  = fetch_inst.alu_fmt.rd;
  assign rs  = fetch_inst.alu_fmt.rs;
  assign rt  = fetch_inst.imm_fmt.rt;
  assign imm = fetch_inst.imm_fmt.imm;

  assign is_alur   = (op1 == op1_alur);
  assign is_branch = (op1 == op1_beq) || (op1 == op1_blt) ||
                     (op1 == op1_ble) || (op1 == op1_bne);
  assign is_jal    = (op1 == op1_jal);
  assign is_load   = (op1 == op1_lw);
  assign is_store  = (op1 == op1_sw);
  assign is_alui   = (op1 == op1_addi) || (op1 == op1_andi) ||
                     (op1 == op1_ori)  || (op1 == op1_xori);
  assign uses_rt   = is_alur || is_branch || is_store; // rt is a source
  assign wregno    = is_alur ? rd : rt;
  assign wr_reg    = (is_alur || is_jal || is_load || is_alui) && (wregno != '0);

  // ----------------------------------------
  // register file and forwarding
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wb_wr_reg) begin
      regs[wb_wregno] <= wb_value;
    end
  end

  // youngest writer wins; the wb case is the write-through
  function automatic logic [dbits-1:0] operand(input logic [regno_bits-1:0] r);
    return (r == '0)                         ? '0 :
           (ex_wr_reg   && ex_wregno == r)   ? ex_result :
           (ex_q_wr_reg && ex_q_wregno == r) ? mem_fwd_value :
           (wb_wr_reg   && wb_wregno == r)   ? wb_value :
                                               regs[r];
  endfunction

  always_comb begin
    rs_val = operand(rs);
    rt_val = operand(rt);
  end

  // load result is not ready until the memory stage
  assign stall = ex_is_load && ex_wr_reg &&
                 ((ex_wregno == rs) || (uses_rt && ex_wregno == rt));

  // decode latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_valid  <= 1'b0;
      dec_wr_reg <= 1'b0;
    end else if (stall || redirect) begin
      dec_valid  <= 1'b0;          // bubble into execute
      dec_wr_reg <= 1'b0;
    end else begin
      dec_valid  <= 1'b1;
      dec_wr_reg <= wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    dec_pc     <= fetch_pc;
    dec_inst   <= fetch_inst;
    dec_rs_val <= rs_val;
    dec_rt_val <= rt_val;
    dec_imm    <= {{(dbits-16){imm[15]}}, imm};
    dec_wregno <= wregno;
  end

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
  parameter int imem_addr_bits = 10
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      imem_we,
  input  logic [imem_addr_bits-1:0] imem_addr,
  input  logic [31:0]               imem_wdata,
  input  logic                      stall,
  input  logic                      redirect,
  input  logic [dbits-1:0]          redirect_pc,
  output logic [dbits-1:0]          fetch_pc,
  output inst_t                     fetch_inst
);

  logic [dbits-1:0] pc;
  logic [31:0]      imem [0:(1<<imem_addr_bits)-1]; // word addressed
  logic [31:0]      imem_rdata;

  // program load port, used while reset is held
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  assign imem_rdata = imem[pc[imem_addr_bits+1:2]];

  // ----------------------------------------
  // program counter
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= start_pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // fetch latch; an all-zero word is alur into r0, so it writes nothing
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetch_inst <= '0;
    end else if (redirect) begin
      fetch_inst <= '0;            // wrong-path fetch
    end else if (!stall) begin
      fetch_inst <= inst_t'(imem_rdata);
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      fetch_pc <= pc;
    end
  end

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int dbits      = 32;
  localparam int regno_bits = 4;

  localparam logic [dbits-1:0] start_pc  = 32'h0000_0100;
  localparam logic [dbits-1:0] addr_hex  = 32'hFFFF_F000;
  localparam logic [dbits-1:0] addr_ledr = 32'hFFFF_F020;
  localparam logic [dbits-1:0] addr_key  = 32'hFFFF_F080;

  // ----------------------------------------
  // primary opcodes, inst[31:26]
  // ----------------------------------------
  localparam logic [5:0] op1_alur = 6'b000000;
  localparam logic [5:0] op1_beq  = 6'b001000;
  localparam logic [5:0] op1_blt  = 6'b001001;
  localparam logic [5:0] op1_ble  = 6'b001010;
  localparam logic [5:0] op1_bne  = 6'b001011;
  localparam logic [5:0] op1_jal  = 6'b001100;
  localparam logic [5:0] op1_lw   = 6'b010010;
  localparam logic [5:0] op1_sw   = 6'b011010;
  localparam logic [5:0] op1_addi = 6'b100000;
  localparam logic [5:0] op1_andi = 6'b100100;
  localparam logic [5:0] op1_ori  = 6'b100101;
  localparam logic [5:0] op1_xori = 6'b100110;

  // ----------------------------------------
  // alur secondary opcodes, inst[25:18]
  // ----------------------------------------
  localparam logic [7:0] op2_eq   = 8'b00001000;
  localparam logic [7:0] op2_lt   = 8'b00001001;
  localparam logic [7:0] op2_le   = 8'b00001010;
  localparam logic [7:0] op2_ne   = 8'b00001011;
  localparam logic [7:0] op2_add  = 8'b00100000;
  localparam logic [7:0] op2_and  = 8'b00100100;
  localparam logic [7:0] op2_or   = 8'b00100101;
  localparam logic [7:0] op2_xor  = 8'b00100110;
  localparam logic [7:0] op2_sub  = 8'b00101000;
  localparam logic [7:0] op2_nand = 8'b00101100;
  localparam logic [7:0] op2_nor  = 8'b00101101;
  localparam logic [7:0] op2_nxor = 8'b00101110;
  localparam logic [7:0] op2_rshf = 8'b00110000;
  localparam logic [7:0] op2_lshf = 8'b00110001;

  // same 32-bit word, register form and immediate form
  typedef union packed {
    struct packed {
      logic [5:0]            op1;
      logic [7:0]            op2;
      logic [5:0]            unused;
      logic [regno_bits-1:0] rd;
      logic [regno_bits-1:0] rs;
      logic [regno_bits-1:0] rt;
    } alu_fmt;
    struct packed {
      logic [5:0]            op1;
      logic [1:0]            unused;
      logic [15:0]           imm;
      logic [regno_bits-1:0] rs;
      logic [regno_bits-1:0] rt;
    } imm_fmt;
  } inst_t;

endpackage

`default_nettype wire
